// ==== design/lstm_fixed_pkg.sv ====
package lstm_fixed_pkg;

  // Q3.12 signed fixed point
  localparam int data_width = 16;
  localparam int frac_bits  = 12;

  typedef logic signed [data_width-1:0]   fix_t;
  // Holds a full product before saturation
  typedef logic signed [2*data_width-1:0] fix_wide_t;

  localparam fix_t fix_one     = 16'sd4096;
  localparam fix_t fix_neg_one = -16'sd4096;
  localparam fix_t fix_half    = 16'sd2048;
  localparam fix_t fix_max     = 16'sh7fff;
  localparam fix_t fix_min     = 16'sh8000;

  // Full product, arithmetic shift back to 12 fraction bits
  function automatic fix_wide_t fix_mul(input fix_t a, input fix_t b);
    return (fix_wide_t'(a) * fix_wide_t'(b)) >>> frac_bits;
  endfunction

  // Clamp a wide sum into the 16-bit range
  function automatic fix_t fix_sat(input fix_wide_t v);
    if (v > fix_wide_t'(fix_max)) begin
      return fix_max;
    end
    if (v < fix_wide_t'(fix_min)) begin
      return fix_min;
    end
    return fix_t'(v);
  endfunction

  // clamp(z/4 + 0.5, 0, 1)
  function automatic fix_t hard_sigmoid(input fix_t z);
    fix_wide_t v;
    v = fix_wide_t'(z >>> 2) + fix_wide_t'(fix_half);
    if (v < 0) begin
      return '0;
    end
    if (v > fix_wide_t'(fix_one)) begin
      return fix_one;
    end
    return fix_t'(v);
  endfunction

  // clamp(z, -1, 1)
  function automatic fix_t hard_tanh(input fix_t z);
    if (z > fix_one) begin
      return fix_one;
    end
    if (z < fix_neg_one) begin
      return fix_neg_one;
    end
    return z;
  endfunction

endpackage

// ==== design/lstm_ctrl_pkg.sv ====
package lstm_ctrl_pkg;

  // Number of elements L per step
  localparam int vec_len   = 8;
  localparam int idx_width = 3;

  typedef logic [idx_width-1:0] idx_t;
  // One extra bit so a count can reach vec_len
  typedef logic [idx_width:0]   cnt_t;

  // Gate select for weight loading
  typedef enum logic [1:0] {
    gate_act,
    gate_in,
    gate_forget,
    gate_out
  } gate_e;

  // Step sequencer states
  typedef enum logic [1:0] {
    seq_idle,
    seq_run,
    seq_drain,
    seq_done
  } seq_state_e;

  // Cycles from accepted x to o_h_valid
  localparam int pipe_latency = 4;

endpackage

// ==== design/lstm_weight_bank.sv ====
`timescale 1ns/1ps

module lstm_weight_bank (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  i_load_en,
  input  lstm_ctrl_pkg::gate_e  i_load_gate,
  input  lstm_ctrl_pkg::idx_t   i_load_idx,
  input  lstm_fixed_pkg::fix_t  i_load_w,
  input  lstm_fixed_pkg::fix_t  i_load_b,
  input  lstm_ctrl_pkg::idx_t   i_rd_idx,
  output lstm_fixed_pkg::fix_t  o_w_act,
  output lstm_fixed_pkg::fix_t  o_w_in,
  output lstm_fixed_pkg::fix_t  o_w_forget,
  output lstm_fixed_pkg::fix_t  o_w_out,
  output lstm_fixed_pkg::fix_t  o_b_act,
  output lstm_fixed_pkg::fix_t  o_b_in,
  output lstm_fixed_pkg::fix_t  o_b_forget,
  output lstm_fixed_pkg::fix_t  o_b_out
);
  import lstm_fixed_pkg::*;
  import lstm_ctrl_pkg::*;

  // One row per gate, one word per element
  fix_t w_mem [0:3][0:vec_len-1];
  fix_t b_mem [0:3][0:vec_len-1];

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int g = 0; g < 4; g++) begin
        for (int e = 0; e < vec_len; e++) begin
          w_mem[g][e] <= '0;
          b_mem[g][e] <= '0;
        end
      end
    end else if (i_load_en) begin
      w_mem[i_load_gate][i_load_idx] <= i_load_w;
      b_mem[i_load_gate][i_load_idx] <= i_load_b;
    end
  end

  // Asynchronous read of all four gates
  assign o_w_act    = w_mem[gate_act][i_rd_idx];
  assign o_w_in     = w_mem[gate_in][i_rd_idx];
  assign o_w_forget = w_mem[gate_forget][i_rd_idx];
  assign o_w_out    = w_mem[gate_out][i_rd_idx];

  assign o_b_act    = b_mem[gate_act][i_rd_idx];
  assign o_b_in     = b_mem[gate_in][i_rd_idx];
  assign o_b_forget = b_mem[gate_forget][i_rd_idx];
  assign o_b_out    = b_mem[gate_out][i_rd_idx];

endmodule

// ==== design/lstm_gate_pipe.sv ====
`timescale 1ns/1ps

module lstm_gate_pipe (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  i_x_accept,
  input  lstm_fixed_pkg::fix_t  i_x,
  input  lstm_ctrl_pkg::idx_t   i_idx,
  input  lstm_fixed_pkg::fix_t  i_w_act,
  input  lstm_fixed_pkg::fix_t  i_w_in,
  input  lstm_fixed_pkg::fix_t  i_w_forget,
  input  lstm_fixed_pkg::fix_t  i_w_out,
  input  lstm_fixed_pkg::fix_t  i_b_act,
  input  lstm_fixed_pkg::fix_t  i_b_in,
  input  lstm_fixed_pkg::fix_t  i_b_forget,
  input  lstm_fixed_pkg::fix_t  i_b_out,
  output logic                  o_valid,
  output lstm_ctrl_pkg::idx_t   o_idx,
  output lstm_fixed_pkg::fix_t  o_a,
  output lstm_fixed_pkg::fix_t  o_i,
  output lstm_fixed_pkg::fix_t  o_f,
  output lstm_fixed_pkg::fix_t  o_o
);
  import lstm_fixed_pkg::*;
  import lstm_ctrl_pkg::*;

  // Stage 1 registers
  logic s1_valid;
  idx_t s1_idx;
  fix_t z_a;
  fix_t z_i;
  fix_t z_f;
  fix_t z_o;

  // Pre-activation for each gate
  fix_t pre_a;
  fix_t pre_i;
  fix_t pre_f;
  fix_t pre_o;

  ////////////////////////////////////////////////////////////////////////////
  // Stage 1, z = w*x + b
  ////////////////////////////////////////////////////////////////////////////

  // Product stays wide, only the sum is saturated
  assign pre_a = fix_sat(fix_mul(i_w_act, i_x) + fix_wide_t'(i_b_act));
  assign pre_i = fix_sat(fix_mul(i_w_in, i_x) + fix_wide_t'(i_b_in));
  assign pre_f = fix_sat(fix_mul(i_w_forget, i_x) + fix_wide_t'(i_b_forget));
  assign pre_o = fix_sat(fix_mul(i_w_out, i_x) + fix_wide_t'(i_b_out));

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= i_x_accept;
    end
  end

  always_ff @(posedge CLK) begin
    if (i_x_accept) begin
      s1_idx <= i_idx;
      z_a    <= pre_a;
      z_i    <= pre_i;
      z_f    <= pre_f;
      z_o    <= pre_o;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage 2, activations
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= s1_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (s1_valid) begin
      o_idx <= s1_idx;
      // Activation gate uses tanh, the others sigmoid
      o_a   <= hard_tanh(z_a);
      o_i   <= hard_sigmoid(z_i);
      o_f   <= hard_sigmoid(z_f);
      o_o   <= hard_sigmoid(z_o);
    end
  end

endmodule

// ==== design/lstm_cell_update.sv ====
`timescale 1ns/1ps

module lstm_cell_update (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  i_valid,
  input  lstm_ctrl_pkg::idx_t   i_idx,
  input  lstm_fixed_pkg::fix_t  i_a,
  input  lstm_fixed_pkg::fix_t  i_i,
  input  lstm_fixed_pkg::fix_t  i_f,
  input  lstm_fixed_pkg::fix_t  i_o,
  output logic                  o_h_valid,
  output lstm_fixed_pkg::fix_t  o_h
);
  import lstm_fixed_pkg::*;
  import lstm_ctrl_pkg::*;

  // Cell state, kept across steps
  fix_t s_mem [0:vec_len-1];

  // Stage 3 registers
  logic s3_valid;
  fix_t s3_s;
  fix_t s3_o;

  fix_t s_next;

  ////////////////////////////////////////////////////////////////////////////
  // Stage 3, s = f*s + i*a
  ////////////////////////////////////////////////////////////////////////////

  assign s_next = fix_sat(fix_mul(i_f, s_mem[i_idx]) + fix_mul(i_i, i_a));

  // Each index appears once per step, so no read-after-write hazard
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int e = 0; e < vec_len; e++) begin
        s_mem[e] <= '0;
      end
      s3_valid <= 1'b0;
    end else begin
      s3_valid <= i_valid;
      if (i_valid) begin
        s_mem[i_idx] <= s_next;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (i_valid) begin
      s3_s <= s_next;
      s3_o <= i_o;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage 4, h = o*hardtanh(s)
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      o_h_valid <= 1'b0;
    end else begin
      o_h_valid <= s3_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (s3_valid) begin
      o_h <= fix_sat(fix_mul(s3_o, hard_tanh(s3_s)));
    end
  end

endmodule

// ==== design/lstm_sequencer.sv ====
`timescale 1ns/1ps

module lstm_sequencer (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 i_start,
  input  logic                 i_x_valid,
  input  logic                 i_h_valid,
  output logic                 o_load_en,
  output logic                 o_x_accept,
  output lstm_ctrl_pkg::idx_t  o_x_idx,
  output logic                 o_busy,
  output logic                 o_done
);
  import lstm_ctrl_pkg::*;

  seq_state_e state;
  cnt_t       in_cnt;
  cnt_t       out_cnt;

  // Inputs only count while running
  assign o_x_accept = i_x_valid && (state == seq_run);
  assign o_x_idx    = in_cnt[idx_width-1:0];
  assign o_load_en  = (state == seq_idle);
  assign o_busy     = (state == seq_run) || (state == seq_drain);

  // Last hidden output of the step
  assign o_done = (state == seq_drain) && i_h_valid && (out_cnt == cnt_t'(vec_len - 1));

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state   <= seq_idle;
      in_cnt  <= '0;
      out_cnt <= '0;
    end else begin
      if (o_busy && i_h_valid) begin
        out_cnt <= out_cnt + 1'b1;
      end
      case (state)
        seq_idle: begin
          if (i_start) begin
            in_cnt  <= '0;
            out_cnt <= '0;
            state   <= seq_run;
          end
        end
        seq_run: begin
          if (o_x_accept) begin
            in_cnt <= in_cnt + 1'b1;
            if (in_cnt == cnt_t'(vec_len - 1)) begin
              state <= seq_drain;
            end
          end
        end
        seq_drain: begin
          if (o_done) begin
            state <= seq_done;
          end
        end
        default: begin
          state <= seq_idle;
        end
      endcase
    end
  end

endmodule

// ==== design/lstm_cell_top.sv ====
`timescale 1ns/1ps

module lstm_cell_top (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  i_load,
  input  lstm_ctrl_pkg::gate_e  i_load_gate,
  input  lstm_ctrl_pkg::idx_t   i_load_idx,
  input  lstm_fixed_pkg::fix_t  i_load_w,
  input  lstm_fixed_pkg::fix_t  i_load_b,
  input  logic                  i_start,
  input  logic                  i_x_valid,
  input  lstm_fixed_pkg::fix_t  i_x,
  output logic                  o_h_valid,
  output lstm_fixed_pkg::fix_t  o_h,
  output logic                  o_busy,
  output logic                  o_done
);
  import lstm_fixed_pkg::*;
  import lstm_ctrl_pkg::*;

  logic load_en;
  logic bank_we;
  logic x_accept;
  idx_t x_idx;

  // Bank read data
  fix_t w_act, w_in, w_forget, w_out;
  fix_t b_act, b_in, b_forget, b_out;

  // Activated gates toward the cell update
  logic g_valid;
  idx_t g_idx;
  fix_t g_a, g_i, g_f, g_o;

  // Loads only land while idle
  assign bank_we = i_load && load_en;

  lstm_sequencer u_seq (
    .CLK(CLK), .RST(RST),
    .i_start(i_start), .i_x_valid(i_x_valid), .i_h_valid(o_h_valid),
    .o_load_en(load_en), .o_x_accept(x_accept), .o_x_idx(x_idx),
    .o_busy(o_busy), .o_done(o_done)
  );

  lstm_weight_bank u_bank (
    .CLK(CLK), .RST(RST),
    .i_load_en(bank_we), .i_load_gate(i_load_gate), .i_load_idx(i_load_idx),
    .i_load_w(i_load_w), .i_load_b(i_load_b), .i_rd_idx(x_idx),
    .o_w_act(w_act), .o_w_in(w_in), .o_w_forget(w_forget), .o_w_out(w_out),
    .o_b_act(b_act), .o_b_in(b_in), .o_b_forget(b_forget), .o_b_out(b_out)
  );

  lstm_gate_pipe u_gates (
    .CLK(CLK), .RST(RST),
    .i_x_accept(x_accept), .i_x(i_x), .i_idx(x_idx),
    .i_w_act(w_act), .i_w_in(w_in), .i_w_forget(w_forget), .i_w_out(w_out),
    .i_b_act(b_act), .i_b_in(b_in), .i_b_forget(b_forget), .i_b_out(b_out),
    .o_valid(g_valid), .o_idx(g_idx),
    .o_a(g_a), .o_i(g_i), .o_f(g_f), .o_o(g_o)
  );

  lstm_cell_update u_cell (
    .CLK(CLK), .RST(RST),
    .i_valid(g_valid), .i_idx(g_idx),
    .i_a(g_a), .i_i(g_i), .i_f(g_f), .i_o(g_o),
    .o_h_valid(o_h_valid), .o_h(o_h)
  );

endmodule

// ==== test/lstm_cell_props.sv ====
`timescale 1ns/1ps

module lstm_cell_props (
  input logic                      CLK,
  input logic                      RST,
  input logic                      i_start,
  input logic                      i_x_accept,
  input logic                      i_h_valid,
  input logic                      i_busy,
  input logic                      i_done,
  input lstm_ctrl_pkg::seq_state_e i_state
);
  import lstm_ctrl_pkg::*;

  // Failed assertion count read by the testbench
  int err_count = 0;

  // Hidden output follows each accepted x by pipe_latency cycles
  a_latency: assert property (@(posedge CLK) disable iff (RST)
    i_h_valid == $past(i_x_accept, pipe_latency))
    else begin
      $error("o_h_valid is not pipe_latency cycles after an accepted x");
      err_count = err_count + 1;
    end

  // Done hands over to seq_done and then back to idle
  a_done_state: assert property (@(posedge CLK) disable iff (RST)
    i_done |=> (i_state == seq_done) ##1 (i_state == seq_idle))
    else begin
      $error("o_done not followed by seq_done and then seq_idle");
      err_count = err_count + 1;
    end

  a_reset_idle: assert property (@(posedge CLK) RST |-> !i_busy)
    else begin
      $error("o_busy high during reset");
      err_count = err_count + 1;
    end

  a_busy_start: assert property (@(posedge CLK) disable iff (RST)
    $rose(i_busy) |-> $past(i_start))
    else begin
      $error("o_busy rose without i_start");
      err_count = err_count + 1;
    end

endmodule

bind lstm_sequencer lstm_cell_props u_props (
  .CLK(CLK),
  .RST(RST),
  .i_start(i_start),
  .i_x_accept(o_x_accept),
  .i_h_valid(i_h_valid),
  .i_busy(o_busy),
  .i_done(o_done),
  .i_state(state)
);

// ==== test/lstm_cell_tb.sv ====
`timescale 1ns/1ps

module lstm_cell_tb;
  import lstm_fixed_pkg::*;
  import lstm_ctrl_pkg::*;

  localparam int num_steps      = 7;
  localparam int max_gap        = 3;
  localparam int load_phases    = 2;
  localparam int reset_cycles   = 16;
  localparam int step_cycles    = vec_len * (max_gap + 1) + pipe_latency + 10;
  localparam int timeout_cycles = reset_cycles + load_phases * 4 * vec_len
                                  + num_steps * step_cycles + 100;

  logic  CLK;
  logic  RST;
  logic  load;
  gate_e load_gate;
  idx_t  load_idx;
  fix_t  load_w;
  fix_t  load_b;
  logic  start;
  logic  x_valid;
  fix_t  x;
  logic  h_valid;
  fix_t  h;
  logic  busy;
  logic  done;

  // Reference model state
  int w_ref   [0:3][0:vec_len-1];
  int b_ref   [0:3][0:vec_len-1];
  int model_s [0:vec_len-1];
  int exp_h   [$];
  int exp_idx [$];

  int seed = 32'he73b81a2;
  int done_count = 0;
  int steps_run  = 0;
  int cycle_cnt  = 0;
  int h_in_step  = 0;
  int want_h;
  int want_idx;

  lstm_cell_top UUT (
    .CLK(CLK), .RST(RST),
    .i_load(load), .i_load_gate(load_gate), .i_load_idx(load_idx),
    .i_load_w(load_w), .i_load_b(load_b),
    .i_start(start), .i_x_valid(x_valid), .i_x(x),
    .o_h_valid(h_valid), .o_h(h), .o_busy(busy), .o_done(done)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Fixed-point reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic int clip(input int v, input int lo, input int hi);
    if (v < lo) return lo;
    if (v > hi) return hi;
    return v;
  endfunction

  function automatic int qmul(input int a, input int b);
    int p;
    p = a * b;
    return p >>> frac_bits;
  endfunction

  function automatic int sat16(input int v);
    return clip(v, int'(fix_min), int'(fix_max));
  endfunction

  function automatic int sig_clip(input int z);
    return clip((z >>> 2) + int'(fix_half), 0, int'(fix_one));
  endfunction

  function automatic int tanh_clip(input int z);
    return clip(z, -int'(fix_one), int'(fix_one));
  endfunction

  // One element through all four stages with in-place state update
  function automatic int predict_h(input int e, input int xv);
    int za, zi, zf, zo;
    int a, ig, f, o, s;
    za = sat16(qmul(w_ref[0][e], xv) + b_ref[0][e]);
    zi = sat16(qmul(w_ref[1][e], xv) + b_ref[1][e]);
    zf = sat16(qmul(w_ref[2][e], xv) + b_ref[2][e]);
    zo = sat16(qmul(w_ref[3][e], xv) + b_ref[3][e]);
    a  = tanh_clip(za);
    ig = sig_clip(zi);
    f  = sig_clip(zf);
    o  = sig_clip(zo);
    s  = sat16(qmul(f, model_s[e]) + qmul(ig, a));
    model_s[e] = s;
    return sat16(qmul(o, tanh_clip(s)));
  endfunction

  // Uniform in -limit..limit
  function automatic int rand_fix(input int limit);
    int r;
    r = $random(seed);
    return r % (limit + 1);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and failure handling
  ////////////////////////////////////////////////////////////////////////////

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic load_weight(input int g, input int e, input int w, input int b);
    fix_t wv;
    fix_t bv;
    wv = fix_t'(w);
    bv = fix_t'(b);
    load      = 1'b1;
    load_gate = gate_e'(g);
    load_idx  = idx_t'(e);
    load_w    = wv;
    load_b    = bv;
    w_ref[g][e] = int'(wv);
    b_ref[g][e] = int'(bv);
    @(negedge CLK);
    load = 1'b0;
  endtask

  task automatic send_x(input int e, input int xv, input int gap);
    x_valid = 1'b1;
    x       = fix_t'(xv);
    exp_h.push_back(predict_h(e, xv));
    exp_idx.push_back(e);
    @(negedge CLK);
    x_valid = 1'b0;
    repeat (gap) @(negedge CLK);
  endtask

  // Load and x strobes that the busy cell must drop
  task automatic strobe_while_busy();
    assert (busy) else fail_now("o_busy low before the ignored strobes");
    load      = 1'b1;
    load_gate = gate_out;
    load_idx  = '0;
    load_w    = 16'sh1000;
    load_b    = 16'sh0800;
    x_valid   = 1'b1;
    x         = 16'sh1234;
    repeat (2) @(negedge CLK);
    load    = 1'b0;
    x_valid = 1'b0;
  endtask

  task automatic run_step(input bit gaps, input bit extremes, input bit poke);
    int xv;
    int gap;
    start = 1'b1;
    @(negedge CLK);
    start = 1'b0;
    assert (busy) else fail_now("o_busy did not rise after i_start");
    for (int e = 0; e < vec_len; e++) begin
      if (extremes) begin
        xv = (($random(seed) & 1) != 0) ? 32767 : -32768;
      end else begin
        xv = rand_fix(8192);
      end
      gap = gaps ? ($random(seed) & max_gap) : 0;
      send_x(e, xv, gap);
    end
    if (poke) begin
      strobe_while_busy();
    end
    while (busy) @(negedge CLK);
    steps_run++;
    assert (done_count == steps_run)
      else fail_now($sformatf("Mismatch o_done count: got %h expected %h",
                              done_count, steps_run));
    assert (exp_h.size() == 0) else fail_now("step ended with hidden outputs missing");
    // Sequencer passes through seq_done back to idle
    @(negedge CLK);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitors
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge CLK) begin
    if (h_valid) begin
      h_in_step++;
      if (exp_h.size() == 0) begin
        fail_now("o_h_valid with no accepted input waiting");
      end else begin
        want_h   = exp_h.pop_front();
        want_idx = exp_idx.pop_front();
        assert (h === fix_t'(want_h))
          else fail_now($sformatf("Mismatch o_h[%0d]: got %h expected %h",
                                  want_idx, h, fix_t'(want_h)));
      end
    end
    if (done) begin
      done_count++;
      assert (h_valid && h_in_step == vec_len)
        else fail_now("o_done did not come with the last o_h_valid of the step");
      h_in_step = 0;
    end
  end

  always @(negedge CLK) begin
    if (UUT.u_seq.u_props.err_count != 0) begin
      fail_now("a bound timing assertion failed");
    end
  end

  always @(posedge CLK) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_cycles) begin
      fail_now($sformatf("Timeout after %0d cycles", cycle_cnt));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    RST       = 1'b1;
    load      = 1'b0;
    load_gate = gate_act;
    load_idx  = '0;
    load_w    = '0;
    load_b    = '0;
    start     = 1'b0;
    x_valid   = 1'b0;
    x         = '0;
    for (int e = 0; e < vec_len; e++) begin
      model_s[e] = 0;
      for (int g = 0; g < 4; g++) begin
        w_ref[g][e] = 0;
        b_ref[g][e] = 0;
      end
    end
    repeat (reset_cycles) @(negedge CLK);
    RST = 1'b0;
    @(negedge CLK);
    assert (!busy && !done && !h_valid) else fail_now("outputs not low after reset");

    // Stray x while idle
    x_valid = 1'b1;
    x       = 16'sh1000;
    @(negedge CLK);
    x_valid = 1'b0;

    // Zero weights give h = 0
    run_step(1'b0, 1'b0, 1'b0);

    for (int g = 0; g < 4; g++) begin
      for (int e = 0; e < vec_len; e++) begin
        load_weight(g, e, rand_fix(8192), rand_fix(8192));
      end
    end
    // Back-to-back step with a load and x strobes sent while busy
    run_step(1'b0, 1'b0, 1'b1);
    // State carries over across spaced strobes with the old weights kept
    run_step(1'b1, 1'b0, 1'b0);
    run_step(1'b1, 1'b0, 1'b0);

    // Extreme weights push every clamp
    for (int g = 0; g < 4; g++) begin
      for (int e = 0; e < vec_len; e++) begin
        load_weight(g, e, (e % 2 != 0) ? 32767 : -32768,
                    ((e / 2) % 2 != 0) ? 32767 : -32768);
      end
    end
    run_step(1'b0, 1'b1, 1'b0);
    run_step(1'b0, 1'b1, 1'b0);
    // Extreme weights with moderate inputs
    run_step(1'b1, 1'b0, 1'b0);

    $display("test passed");
    $finish;
  end

endmodule

// ==== tb.f ====
design/lstm_fixed_pkg.sv
design/lstm_ctrl_pkg.sv
design/lstm_weight_bank.sv
design/lstm_gate_pipe.sv
design/lstm_cell_update.sv
design/lstm_sequencer.sv
design/lstm_cell_top.sv
test/lstm_cell_props.sv
test/lstm_cell_tb.sv

// ==== Makefile ====
# Verilator flow for the LSTM cell testbench

VERILATOR ?= verilator
TOP       ?= lstm_cell_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -qx "test passed" $(LOG) || (echo "Simulation FAILED, see $(LOG)"; exit 1)
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
